// ==== all.f ====
+incdir+hdl
hdl/fcore_pkg.sv
hdl/fcore_exec_if.sv
hdl/fcore_result_if.sv
hdl/fcore_program_memory.sv
hdl/fcore_control_unit.sv
hdl/fcore_register_file.sv
hdl/fcore_arith_unit.sv
hdl/fcore_logic_unit.sv
hdl/fcore_writeback.sv
hdl/fcore_top.sv
bench/fcore_tb.sv

// ==== bench/fcore_tb.sv ====
`timescale 1ns/100ps
`include "fcore_defs.svh"

module fcore_tb import fcore_pkg::*; ();

    // Budget for the whole run, in clock cycles
    localparam int RUN_CYCLES     = 400;
    localparam int TRAFFIC_CYCLES = 1200;
    localparam int TIMEOUT_CYCLES = 20 * (RUN_CYCLES + TRAFFIC_CYCLES);

    logic           clock = 1'b0;
    logic           rst_n;
    logic           cyc;
    logic           stb;
    logic           we;
    pc_t            adr;
    data_t          dat_w;
    data_t          dat_r;
    logic           ack;
    logic           run;
    channel_count_t n_channels;
    logic           busy;
    logic           done;
    channel_t       rd_channel;
    reg_addr_t      rd_reg;
    data_t          rd_data;

    integer seed = 32'h939c;
    int     cycle_count = 0;
    int     data_errors = 0;
    int     cycle_errors = 0;
    int     other_errors = 0;

    // Model of program memory and of every channel's registers
    data_t  prog_image [`FCORE_PROG_DEPTH];
    data_t  exp_regs [`FCORE_MAX_CHANNELS][`FCORE_REG_COUNT];
    pc_t    emit_addr;

    int     expected_cycles;
    int     run_cycles;
    logic   measuring = 1'b0;
    logic   run_finished = 1'b0;

    fcore_top dut_i (
        .clock      (clock),
        .rst_n      (rst_n),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .adr        (adr),
        .dat_w      (dat_w),
        .dat_r      (dat_r),
        .ack        (ack),
        .run        (run),
        .n_channels (n_channels),
        .busy       (busy),
        .done       (done),
        .rd_channel (rd_channel),
        .rd_reg     (rd_reg),
        .rd_data    (rd_data)
    );

    always #50 clock = ~clock;

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            data_errors++;
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_pc(input string name, input pc_t got, input pc_t exp);
        if (got !== exp) begin
            cycle_errors++;
            $display("Fail at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    function automatic data_t encode(input opcode_t op, input reg_addr_t d,
                                     input reg_addr_t a, input reg_addr_t b);
        return {18'd0, b, a, d, op};
    endfunction

    // Executes the program image on exp_regs and returns the cycles from run to done
    function automatic int ref_run(input channel_count_t n);
        pc_t   pc;
        data_t w;
        data_t a;
        data_t b;
        data_t r;
        logic  write_back;
        logic  stop;
        int    count;
        int    ch;
        pc = '0;
        count = 0;
        stop = 1'b0;
        for (int step = 0; step < `FCORE_PROG_DEPTH && !stop; step++) begin
            w = prog_image[pc];
            if (w[4:0] == 5'd0) begin
                stop = 1'b1;
            end else begin
                for (ch = 0; ch < n; ch++) begin
                    a = exp_regs[ch][w[10:8]];
                    b = exp_regs[ch][w[13:11]];
                    write_back = 1'b1;
                    case (w[4:0])
                        ADD:     r = a + b;
                        SUB:     r = a - b;
                        LDC:     r = prog_image[pc_t'(pc + 1)];
                        CHN:     r = data_t'(ch);
                        AND:     r = a & b;
                        OR:      r = a | b;
                        XOR:     r = a ^ b;
                        SHR:     r = a >> b[4:0];
                        default: write_back = 1'b0;
                    endcase
                    if (write_back) begin
                        exp_regs[ch][w[7:5]] = r;
                    end
                end
                count++;
                pc = pc + ((w[4:0] == LDC) ? 2 : 1);
            end
        end
        return count * (n + 1) + 4;
    endfunction

    task automatic wb_access(input logic write, input pc_t a, input data_t d,
                             output data_t q);
        int waited;
        @(posedge clock);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= write;
        adr   <= a;
        dat_w <= d;
        waited = 0;
        @(negedge clock);
        while (!ack && waited < 16) begin
            @(negedge clock);
            waited++;
        end
        if (!ack) begin
            other_errors++;
            $display("Wishbone ack never arrived for address %0d at %0t", a, $time);
        end
        check_pc("ack latency", pc_t'(waited), pc_t'(1));
        q = dat_r;
        @(posedge clock);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic load_word(input pc_t a, input data_t d);
        data_t q;
        wb_access(1'b1, a, d, q);
        prog_image[a] = d;
    endtask

    task automatic emit(input data_t w);
        load_word(emit_addr, w);
        emit_addr = emit_addr + 1'b1;
    endtask

    task automatic start_run(input channel_count_t n);
        expected_cycles = ref_run(n);
        run_finished = 1'b0;
        @(posedge clock);
        run        <= 1'b1;
        n_channels <= n;
        @(posedge clock);
        run <= 1'b0;
    endtask

    task automatic wait_done();
        while (!run_finished) begin
            @(posedge clock);
        end
    endtask

    task automatic check_all_regs();
        for (int ch = 0; ch < `FCORE_MAX_CHANNELS; ch++) begin
            for (int r = 0; r < `FCORE_REG_COUNT; r++) begin
                @(posedge clock);
                rd_channel <= channel_t'(ch);
                rd_reg     <= reg_addr_t'(r);
                @(posedge clock);
                @(negedge clock);
                check_data($sformatf("rd_data ch%0d r%0d", ch, r), rd_data, exp_regs[ch][r]);
            end
        end
    endtask

    task automatic run_and_check(input channel_count_t n);
        start_run(n);
        wait_done();
        check_all_regs();
    endtask

    // Measures run to done and watches busy, sampled on the falling edge
    always @(negedge clock) begin
        if (!measuring) begin
            if (run && rst_n) begin
                measuring  = 1'b1;
                run_cycles = 0;
            end
        end else if (done) begin
            check_pc("run to done cycles", pc_t'(run_cycles), pc_t'(expected_cycles));
            measuring    = 1'b0;
            run_finished = 1'b1;
        end else begin
            if (!busy) begin
                other_errors++;
                $display("busy went low before done at %0t", $time);
            end
            run_cycles++;
        end
    end

    initial begin
        data_t q;
        rst_n      <= 1'b0;
        cyc        <= 1'b0;
        stb        <= 1'b0;
        we         <= 1'b0;
        adr        <= '0;
        dat_w      <= '0;
        run        <= 1'b0;
        n_channels <= channel_count_t'(1);
        rd_channel <= '0;
        rd_reg     <= '0;
        for (int i = 0; i < `FCORE_PROG_DEPTH; i++) begin
            prog_image[i] = '0;
        end
        for (int ch = 0; ch < `FCORE_MAX_CHANNELS; ch++) begin
            for (int r = 0; r < `FCORE_REG_COUNT; r++) begin
                exp_regs[ch][r] = '0;
            end
        end
        repeat (5) @(posedge clock);
        rst_n <= 1'b1;

        // Random words through the Wishbone port, then read back
        for (int i = 200; i < 216; i++) begin
            load_word(pc_t'(i), data_t'($random(seed)));
        end
        for (int i = 200; i < 216; i++) begin
            wb_access(1'b0, pc_t'(i), '0, q);
            check_data($sformatf("dat_r at %0d", i), q, prog_image[i]);
        end

        // Arithmetic on all eight channels
        emit_addr = '0;
        emit(encode(LDC, 1, 0, 0));
        emit(data_t'($random(seed)));
        emit(encode(LDC, 2, 0, 0));
        emit(data_t'($random(seed)));
        emit(encode(CHN, 3, 0, 0));
        emit(encode(ADD, 4, 1, 3));
        emit(encode(SUB, 5, 2, 4));
        emit(encode(ADD, 6, 5, 5));
        emit(encode(SUB, 7, 3, 1));
        emit(encode(STOP, 0, 0, 0));
        run_and_check(channel_count_t'(8));

        // Logic ops, with r0 holding a shift count above 31
        emit_addr = '0;
        emit(encode(LDC, 1, 0, 0));
        emit(data_t'($random(seed)));
        emit(encode(LDC, 2, 0, 0));
        emit(data_t'($random(seed)));
        emit(encode(LDC, 0, 0, 0));
        emit(32'hffff_ffe5);
        emit(encode(CHN, 3, 0, 0));
        emit(encode(SHR, 4, 1, 3));
        emit(encode(AND, 5, 1, 2));
        emit(encode(OR, 6, 1, 2));
        emit(encode(XOR, 7, 6, 3));
        emit(encode(SHR, 2, 1, 0));
        emit(encode(STOP, 0, 0, 0));
        run_and_check(channel_count_t'(8));

        // Constant words that look like an ADD and like a STOP
        emit_addr = '0;
        emit(encode(LDC, 1, 0, 0));
        emit(encode(ADD, 1, 1, 1));
        emit(encode(ADD, 2, 1, 1));
        emit(encode(LDC, 3, 0, 0));
        emit(32'h0000_0000);
        emit(encode(XOR, 4, 3, 1));
        emit(encode(STOP, 0, 0, 0));
        run_and_check(channel_count_t'(4));

        // A chain where each step reads the previous result
        emit_addr = '0;
        emit(encode(LDC, 1, 0, 0));
        emit(data_t'($random(seed)));
        emit(encode(ADD, 2, 1, 1));
        emit(encode(SUB, 3, 2, 1));
        emit(encode(XOR, 4, 3, 2));
        emit(encode(SHR, 5, 4, 1));
        emit(encode(OR, 6, 5, 4));
        emit(encode(ADD, 7, 6, 7));
        emit(encode(AND, 0, 7, 2));
        emit(encode(STOP, 0, 0, 0));
        run_and_check(channel_count_t'(1));

        // A write while busy must not reach the memory
        start_run(channel_count_t'(3));
        wb_access(1'b1, pc_t'(210), ~prog_image[210], q);
        wait_done();
        wb_access(1'b0, pc_t'(210), '0, q);
        check_data("dat_r at 210 after busy write", q, prog_image[210]);
        check_all_regs();
        run_and_check(channel_count_t'(5));
        run_and_check(channel_count_t'(8));

        $display("Errors: data %0d, cycle %0d, other %0d",
                 data_errors, cycle_errors, other_errors);
        if (data_errors + cycle_errors + other_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== hdl/fcore_top.sv ====
`timescale 1ns/100ps

module fcore_top import fcore_pkg::*; (
    input  logic           clock,
    input  logic           rst_n,
    input  logic           cyc,
    input  logic           stb,
    input  logic           we,
    input  pc_t            adr,
    input  data_t          dat_w,
    output data_t          dat_r,
    output logic           ack,
    input  logic           run,
    input  channel_count_t n_channels,
    output logic           busy,
    output logic           done,
    input  channel_t       rd_channel,
    input  reg_addr_t      rd_reg,
    output data_t          rd_data
);

    pc_t   fetch_pc;
    data_t fetch_word0;
    data_t fetch_word1;

    fcore_exec_if   issue ();
    fcore_result_if arith_res ();
    fcore_result_if logic_res ();
    fcore_result_if wr ();

    fcore_program_memory program_memory_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .cyc         (cyc),
        .stb         (stb),
        .we          (we),
        .adr         (adr),
        .dat_w       (dat_w),
        .dat_r       (dat_r),
        .ack         (ack),
        .busy        (busy),
        .fetch_pc    (fetch_pc),
        .fetch_word0 (fetch_word0),
        .fetch_word1 (fetch_word1)
    );

    fcore_control_unit control_unit_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .run         (run),
        .n_channels  (n_channels),
        .fetch_pc    (fetch_pc),
        .fetch_word0 (fetch_word0),
        .fetch_word1 (fetch_word1),
        .busy        (busy),
        .done        (done),
        .issue       (issue.control)
    );

    fcore_register_file register_file_i (
        .clock      (clock),
        .rst_n      (rst_n),
        .ops        (issue.regfile),
        .wr         (wr.consumer),
        .rd_channel (rd_channel),
        .rd_reg     (rd_reg),
        .rd_data    (rd_data)
    );

    fcore_arith_unit arith_unit_i (
        .clock (clock),
        .rst_n (rst_n),
        .issue (issue.unit),
        .res   (arith_res.producer)
    );

    fcore_logic_unit logic_unit_i (
        .clock (clock),
        .rst_n (rst_n),
        .issue (issue.unit),
        .res   (logic_res.producer)
    );

    fcore_writeback writeback_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .arith_res (arith_res.consumer),
        .logic_res (logic_res.consumer),
        .wr        (wr.producer)
    );

endmodule

// ==== hdl/fcore_writeback.sv ====
`timescale 1ns/100ps

module fcore_writeback import fcore_pkg::*; #(
    parameter bit ARITH_FIRST = 1'b1
) (
    input  logic             clock,
    input  logic             rst_n,
    fcore_result_if.consumer arith_res,
    fcore_result_if.consumer logic_res,
    fcore_result_if.producer wr
);

    logic use_arith;

    // The units decode disjoint opcodes, so a collision only picks a fixed winner
    assign use_arith = arith_res.valid && (ARITH_FIRST || !logic_res.valid);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr.valid <= 1'b0;
        end else begin
            wr.valid <= arith_res.valid || logic_res.valid;
        end
    end

    always_ff @(posedge clock) begin
        if (use_arith) begin
            wr.channel <= arith_res.channel;
            wr.dest    <= arith_res.dest;
            wr.value   <= arith_res.value;
        end else begin
            wr.channel <= logic_res.channel;
            wr.dest    <= logic_res.dest;
            wr.value   <= logic_res.value;
        end
    end

endmodule

// ==== hdl/fcore_logic_unit.sv ====
`timescale 1ns/100ps
`include "fcore_defs.svh"

module fcore_logic_unit import fcore_pkg::*; #(
    parameter int SHAMT_WIDTH = $clog2(`FCORE_DATA_WIDTH)
) (
    input  logic             clock,
    input  logic             rst_n,
    fcore_exec_if.unit       issue,
    fcore_result_if.producer res
);

    logic  accept;
    data_t result;

    assign accept = issue.valid && (issue.opcode inside {AND, OR, XOR, SHR});

    // Only the low bits of b count as shift amount
    always_comb begin
        case (issue.opcode)
            AND:     result = issue.operand_a & issue.operand_b;
            OR:      result = issue.operand_a | issue.operand_b;
            XOR:     result = issue.operand_a ^ issue.operand_b;
            SHR:     result = issue.operand_a >> issue.operand_b[SHAMT_WIDTH-1:0];
            default: result = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= accept;
        end
    end

    always_ff @(posedge clock) begin
        res.channel <= issue.channel;
        res.dest    <= issue.dest;
        res.value   <= result;
    end

endmodule

// ==== hdl/fcore_arith_unit.sv ====
`timescale 1ns/100ps

module fcore_arith_unit import fcore_pkg::*; (
    input  logic             clock,
    input  logic             rst_n,
    fcore_exec_if.unit       issue,
    fcore_result_if.producer res
);

    logic  accept;
    data_t result;

    assign accept = issue.valid && (issue.opcode inside {ADD, SUB, LDC, CHN});

    always_comb begin
        case (issue.opcode)
            ADD:     result = issue.operand_a + issue.operand_b;
            SUB:     result = issue.operand_a - issue.operand_b;
            LDC:     result = issue.constant;
            CHN:     result = data_t'(issue.channel);
            default: result = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= accept;
        end
    end

    always_ff @(posedge clock) begin
        res.channel <= issue.channel;
        res.dest    <= issue.dest;
        res.value   <= result;
    end

endmodule

// ==== hdl/fcore_register_file.sv ====
`timescale 1ns/100ps
`include "fcore_defs.svh"

module fcore_register_file import fcore_pkg::*; (
    input  logic            clock,
    input  logic            rst_n,
    fcore_exec_if.regfile   ops,
    fcore_result_if.consumer wr,
    input  channel_t        rd_channel,
    input  reg_addr_t       rd_reg,
    output data_t           rd_data
);

    // One bank of registers for each channel
    data_t regs [`FCORE_MAX_CHANNELS][`FCORE_REG_COUNT];

    logic fwd_a;
    logic fwd_b;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int ch = 0; ch < `FCORE_MAX_CHANNELS; ch++) begin
                for (int r = 0; r < `FCORE_REG_COUNT; r++) begin
                    regs[ch][r] <= '0;
                end
            end
        end else if (wr.valid) begin
            regs[wr.channel][wr.dest] <= wr.value;
        end
    end

    // With one active channel the next instruction issues while the previous write
    // is still on the write port, so that write stands in for the bank entry
    assign fwd_a = wr.valid && (wr.channel == ops.channel) && (wr.dest == ops.src_a);
    assign fwd_b = wr.valid && (wr.channel == ops.channel) && (wr.dest == ops.src_b);

    // Operands for the channel being issued are read without a clock
    assign ops.operand_a = fwd_a ? wr.value : regs[ops.channel][ops.src_a];
    assign ops.operand_b = fwd_b ? wr.value : regs[ops.channel][ops.src_b];

    // Host read port with one cycle of latency
    always_ff @(posedge clock) begin
        rd_data <= regs[rd_channel][rd_reg];
    end

endmodule

// ==== hdl/fcore_control_unit.sv ====
`timescale 1ns/100ps
`include "fcore_defs.svh"

module fcore_control_unit import fcore_pkg::*; #(
    parameter int MAX_CHANNELS = `FCORE_MAX_CHANNELS
) (
    input  logic           clock,
    input  logic           rst_n,
    input  logic           run,
    input  channel_count_t n_channels,
    output pc_t            fetch_pc,
    input  data_t          fetch_word0,
    input  data_t          fetch_word1,
    output logic           busy,
    output logic           done,
    fcore_exec_if.control  issue
);

    ctrl_state_t    state;
    pc_t            pc;
    channel_t       channel;
    channel_count_t active_channels;
    channel_count_t start_channels;
    logic           drain_last;
    opcode_t        opcode;
    logic           last_channel;
    pc_t            pc_step;

    assign opcode = opcode_t'(fetch_word0[4:0]);

    // Out of range counts are pulled back into 1 to MAX_CHANNELS
    always_comb begin
        if (n_channels == '0) begin
            start_channels = channel_count_t'(1);
        end else if (n_channels > channel_count_t'(MAX_CHANNELS)) begin
            start_channels = channel_count_t'(MAX_CHANNELS);
        end else begin
            start_channels = n_channels;
        end
    end

    assign last_channel = ({1'b0, channel} == active_channels - 1'b1);

    // LDC carries its constant in the next word, so that word is skipped
    assign pc_step = (opcode == LDC) ? pc_t'(2) : pc_t'(1);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state           <= IDLE;
            pc              <= '0;
            channel         <= '0;
            active_channels <= channel_count_t'(1);
            drain_last      <= 1'b0;
            done            <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (run) begin
                        active_channels <= start_channels;
                        pc              <= '0;
                        channel         <= '0;
                        state           <= FETCH;
                    end
                end
                FETCH: begin
                    // Memory samples pc at the end of this cycle
                    channel <= '0;
                    state   <= ISSUE;
                end
                ISSUE: begin
                    if (opcode == STOP) begin
                        drain_last <= 1'b0;
                        state      <= DRAIN;
                    end else if (last_channel) begin
                        channel <= '0;
                        pc      <= pc + pc_step;
                        state   <= FETCH;
                    end else begin
                        channel <= channel + 1'b1;
                    end
                end
                DRAIN: begin
                    // Two cycles let the last writeback reach the registers
                    if (drain_last) begin
                        done  <= 1'b1;
                        state <= IDLE;
                    end else begin
                        drain_last <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign fetch_pc = pc;
    assign busy     = (state != IDLE);

    // The instruction word stays stable for every channel of the issue
    assign issue.valid    = (state == ISSUE) && (opcode != STOP);
    assign issue.opcode   = opcode;
    assign issue.channel  = channel;
    assign issue.dest     = fetch_word0[7:5];
    assign issue.src_a    = fetch_word0[10:8];
    assign issue.src_b    = fetch_word0[13:11];
    assign issue.constant = fetch_word1;

endmodule

// ==== hdl/fcore_program_memory.sv ====
`timescale 1ns/100ps
`include "fcore_defs.svh"

module fcore_program_memory import fcore_pkg::*; #(
    parameter int DEPTH = `FCORE_PROG_DEPTH
) (
    input  logic  clock,
    input  logic  rst_n,
    input  logic  cyc,
    input  logic  stb,
    input  logic  we,
    input  pc_t   adr,
    input  data_t dat_w,
    output data_t dat_r,
    output logic  ack,
    input  logic  busy,
    input  pc_t   fetch_pc,
    output data_t fetch_word0,
    output data_t fetch_word1
);

    data_t mem [DEPTH];

    logic request;
    pc_t  fetch_pc_next;

    // A new request is one that has not been acknowledged yet
    assign request = cyc && stb && !ack;

    // The second fetch word wraps to address zero at the end of memory
    assign fetch_pc_next = fetch_pc + 1'b1;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= request;
        end
    end

    // Host port. Writes are dropped while the core runs, but still acknowledged
    always_ff @(posedge clock) begin
        if (request && we && !busy) begin
            mem[adr] <= dat_w;
        end
        dat_r <= mem[adr];
    end

    // Fetch port returns the instruction and the word after it
    always_ff @(posedge clock) begin
        fetch_word0 <= mem[fetch_pc];
        fetch_word1 <= mem[fetch_pc_next];
    end

endmodule

// ==== hdl/fcore_result_if.sv ====
`timescale 1ns/100ps

// A single register write, tagged with its channel and destination
interface fcore_result_if import fcore_pkg::*; ();

    logic      valid;
    channel_t  channel;
    reg_addr_t dest;
    data_t     value;

    modport producer (output valid, channel, dest, value);

    modport consumer (input valid, channel, dest, value);

endinterface

// ==== hdl/fcore_exec_if.sv ====
`timescale 1ns/100ps

// Issue bus from the control unit to the register file and the execution units
interface fcore_exec_if import fcore_pkg::*; ();

    logic      valid;
    opcode_t   opcode;
    channel_t  channel;
    reg_addr_t dest;
    reg_addr_t src_a;
    reg_addr_t src_b;
    data_t     constant;
    data_t     operand_a;
    data_t     operand_b;

    modport control (output valid, opcode, channel, dest, src_a, src_b, constant);

    modport regfile (input channel, src_a, src_b, output operand_a, operand_b);

    modport unit (input valid, opcode, channel, dest, src_a, src_b, constant,
                  operand_a, operand_b);

endinterface

// ==== hdl/fcore_pkg.sv ====
package fcore_pkg;

    `include "fcore_defs.svh"

    typedef logic [`FCORE_DATA_WIDTH-1:0] data_t;
    typedef logic [$clog2(`FCORE_PROG_DEPTH)-1:0] pc_t;
    typedef logic [$clog2(`FCORE_REG_COUNT)-1:0] reg_addr_t;
    typedef logic [$clog2(`FCORE_MAX_CHANNELS)-1:0] channel_t;

    // One bit wider than channel_t so that the full count fits
    typedef logic [$clog2(`FCORE_MAX_CHANNELS):0] channel_count_t;

    // Encodings not listed here behave as a no-operation
    typedef enum logic [4:0] {
        STOP = 5'd0,
        ADD  = 5'd1,
        SUB  = 5'd2,
        LDC  = 5'd3,
        CHN  = 5'd4,
        AND  = 5'd5,
        OR   = 5'd6,
        XOR  = 5'd7,
        SHR  = 5'd8
    } opcode_t;

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        ISSUE,
        DRAIN
    } ctrl_state_t;

endpackage

// ==== hdl/fcore_defs.svh ====
`ifndef FCORE_DEFS_SVH
`define FCORE_DEFS_SVH

// Width of a data word and of an instruction word
`define FCORE_DATA_WIDTH 32

// Number of words in the program memory
`define FCORE_PROG_DEPTH 256

// Registers in each channel bank
`define FCORE_REG_COUNT 8

// Upper limit on the number of active channels
`define FCORE_MAX_CHANNELS 8

`endif
